/* src/uart_tx_pkg.sv */
package uart_tx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and reset values
  ////////////////////////////////////////////////////////////////////////////

  parameter int DATA_W = 8;

  // 115200 / 12 = 9600 baud out of reset
  parameter logic [15:0] DIVISOR_RESET = 16'd12;

  // line status flags that are still implemented
  parameter int LSR_THRE_BIT = 5;
  parameter int LSR_TEMT_BIT = 6;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  // offset 0 is THR or DLL and offset 1 is DLM, both selected by DLAB
  typedef enum logic [2:0] {
    ADDR_THR_DLL = 3'd0,
    ADDR_DLM     = 3'd1,
    ADDR_LCR     = 3'd3,
    ADDR_LSR     = 3'd5,
    ADDR_SCR     = 3'd7
  } reg_addr_e;

  // line control register layout
  typedef struct packed {
    logic       dlab;
    logic       break_ctl;
    logic       stick;
    logic       even;
    logic       parity_en;
    logic       stop2;
    logic [1:0] word_len;
  } lcr_t;

  // framing plus baud divisor, as seen by the serializer
  typedef struct packed {
    lcr_t        lcr;
    logic [15:0] divisor;
  } line_cfg_t;

endpackage

/* src/tx_queue_if.sv */
interface tx_queue_if #(
  parameter int DATA_W = uart_tx_pkg::DATA_W
);

  // producer side
  logic              push;
  logic [DATA_W-1:0] wdata;

  // fifo status
  logic              full;
  logic              empty;

  // consumer side, rdata is the head entry (show-ahead)
  logic              pop;
  logic [DATA_W-1:0] rdata;

  modport writer (output push, output wdata, input full, input empty);

  modport queue (input push, input wdata, input pop,
                 output full, output empty, output rdata);

  modport reader (output pop, input empty, input rdata);

endinterface

/* src/uart_regs.sv */
module uart_regs (
  input  logic                             reset,
  input  logic                             baudclk_221184kHz,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [2:0]                       wb_adr,
  input  logic [uart_tx_pkg::DATA_W-1:0]   wb_dat_w,
  output logic                             wb_ack,
  output logic [uart_tx_pkg::DATA_W-1:0]   wb_dat_r,
  tx_queue_if.writer                       q,
  input  logic                             tx_busy,
  output uart_tx_pkg::line_cfg_t           line_cfg
);

  uart_tx_pkg::lcr_t                 lcr;
  logic [uart_tx_pkg::DATA_W-1:0]    dll;
  logic [uart_tx_pkg::DATA_W-1:0]    dlm;
  logic [uart_tx_pkg::DATA_W-1:0]    scr;
  logic [uart_tx_pkg::DATA_W-1:0]    lsr;
  uart_tx_pkg::reg_addr_e            addr;
  logic                              access;
  logic                              wr;

  ////////////////////////////////////////////////////////////////////////////
  // wishbone handshake
  ////////////////////////////////////////////////////////////////////////////

  // one-cycle ack, the master holds its request through it
  always_ff @(posedge baudclk_221184kHz or negedge reset)
  begin
    if (!reset)
    begin
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end
  end

  // everything below acts in the ack cycle
  assign access = wb_cyc && wb_stb && wb_ack;
  assign wr     = access && wb_we;
  assign addr   = uart_tx_pkg::reg_addr_e'(wb_adr);

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge baudclk_221184kHz or negedge reset)
  begin
    if (!reset)
    begin
      lcr <= '0;
      dll <= uart_tx_pkg::DIVISOR_RESET[7:0];
      dlm <= uart_tx_pkg::DIVISOR_RESET[15:8];
      scr <= '0;
    end
    else if (wr)
    begin
      case (addr)
        uart_tx_pkg::ADDR_THR_DLL:
          if (lcr.dlab)
            dll <= wb_dat_w;
        uart_tx_pkg::ADDR_DLM:
          if (lcr.dlab)
            dlm <= wb_dat_w;
        uart_tx_pkg::ADDR_LCR: lcr <= uart_tx_pkg::lcr_t'(wb_dat_w);
        uart_tx_pkg::ADDR_SCR: scr <= wb_dat_w;
        default: ;
      endcase
    end
  end

  // THR write goes straight into the fifo, dropped when full
  assign q.push  = wr && (addr == uart_tx_pkg::ADDR_THR_DLL) && !lcr.dlab && !q.full;
  assign q.wdata = wb_dat_w;

  assign line_cfg.lcr     = lcr;
  assign line_cfg.divisor = {dlm, dll};

  ////////////////////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    lsr = '0;
    lsr[uart_tx_pkg::LSR_THRE_BIT] = q.empty;
    // transmitter fully idle: nothing queued and no frame on the line
    lsr[uart_tx_pkg::LSR_TEMT_BIT] = q.empty && !tx_busy;
  end

  always_comb
  begin
    case (addr)
      uart_tx_pkg::ADDR_THR_DLL: wb_dat_r = lcr.dlab ? dll : '0;
      uart_tx_pkg::ADDR_DLM:     wb_dat_r = lcr.dlab ? dlm : '0;
      uart_tx_pkg::ADDR_LCR:     wb_dat_r = lcr;
      uart_tx_pkg::ADDR_LSR:     wb_dat_r = lsr;
      uart_tx_pkg::ADDR_SCR:     wb_dat_r = scr;
      default:                   wb_dat_r = '0;
    endcase
  end

  // a pushed byte shows up as THRE low on the next cycle
  push_fills_fifo: assert property (@(posedge baudclk_221184kHz) disable iff (!reset)
    q.push |=> !q.empty)
    else $error("tx fifo still empty after a push");

  // master keeps its request steady until it sees ack
  request_held: assert property (@(posedge baudclk_221184kHz) disable iff (!reset)
    wb_cyc && wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_we)
      && $stable(wb_adr) && $stable(wb_dat_w))
    else $error("wishbone request dropped or changed before ack");

endmodule

/* src/tx_fifo.sv */
module tx_fifo #(
  parameter int DEPTH = 16
) (
  input  logic        reset,
  input  logic        baudclk_221184kHz,
  tx_queue_if.queue   q
);

  localparam int AW = $clog2(DEPTH);

  logic [uart_tx_pkg::DATA_W-1:0] mem [DEPTH];

  // extra msb tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign q.empty = (wr_ptr == rd_ptr);
  assign q.full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_push = q.push && !q.full;
  assign do_pop  = q.pop && !q.empty;

  // show-ahead head entry
  assign q.rdata = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge baudclk_221184kHz)
  begin
    if (do_push)
    begin
      mem[wr_ptr[AW-1:0]] <= q.wdata;
    end
  end

  always_ff @(posedge baudclk_221184kHz or negedge reset)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // consumer must look at empty before popping
  no_pop_on_empty: assert property (@(posedge baudclk_221184kHz) disable iff (!reset)
    q.pop |-> !q.empty)
    else $error("pop on empty tx fifo");

endmodule

/* src/uart_serializer.sv */
module uart_serializer #(
  parameter int PRESCALE = 192
) (
  input  logic                    reset,
  input  logic                    baudclk_221184kHz,
  tx_queue_if.reader              q,
  input  uart_tx_pkg::line_cfg_t  line_cfg,
  output logic                    tx_busy,
  output logic                    tx
);

  localparam int DATA_W  = uart_tx_pkg::DATA_W;
  // start + data + parity + two stop bits at most
  localparam int FRAME_W = DATA_W + 4;
  localparam int PW      = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

  logic [PW-1:0]      pre_cnt;
  logic [15:0]        div_cnt;
  logic [15:0]        div_q;
  logic [3:0]         len_q;
  logic [3:0]         bit_cnt;
  logic [FRAME_W-1:0] shift_q;
  logic               load;
  logic               pre_tick;
  logic               bit_tick;
  logic [3:0]         data_len;
  logic [3:0]         frame_len;
  logic [DATA_W-1:0]  masked;
  logic               parity;
  logic [FRAME_W-1:0] frame;

  assign load  = !tx_busy && !q.empty;
  assign q.pop = load;
  assign tx    = shift_q[0];

  ////////////////////////////////////////////////////////////////////////////
  // baud tick, both counters restart with each frame
  ////////////////////////////////////////////////////////////////////////////

  assign pre_tick = (pre_cnt == PW'(PRESCALE - 1));
  assign bit_tick = tx_busy && pre_tick && (div_cnt == div_q - 16'd1);

  always_ff @(posedge baudclk_221184kHz or negedge reset)
  begin
    if (!reset)
    begin
      pre_cnt <= '0;
      div_cnt <= '0;
    end
    else if (load)
    begin
      pre_cnt <= '0;
      div_cnt <= '0;
    end
    else if (tx_busy)
    begin
      if (pre_tick)
      begin
        pre_cnt <= '0;
        div_cnt <= (div_cnt == div_q - 16'd1) ? 16'd0 : div_cnt + 16'd1;
      end
      else
      begin
        pre_cnt <= pre_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame build
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    data_len = 4'd5 + {2'b00, line_cfg.lcr.word_len};
    masked   = '0;
    for (int i = 0; i < DATA_W; i++)
    begin
      if (i < data_len)
        masked[i] = q.rdata[i];
    end
    // stick parity sends the inverse of the even bit
    if (line_cfg.lcr.stick)
      parity = !line_cfg.lcr.even;
    else
      parity = (^masked) ^ !line_cfg.lcr.even;
    // unused upper bits stay 1 and form the stop bits
    frame    = '1;
    frame[0] = 1'b0;
    frame[DATA_W:1] = masked | ~({DATA_W{1'b1}} >> (4'd8 - data_len));
    if (line_cfg.lcr.parity_en)
      frame[data_len + 4'd1] = parity;
    frame_len = data_len + 4'd2 + {3'b000, line_cfg.lcr.parity_en}
              + {3'b000, line_cfg.lcr.stop2};
  end

  // shift out lsb first, refilling with idle level
  always_ff @(posedge baudclk_221184kHz or negedge reset)
  begin
    if (!reset)
    begin
      tx_busy <= 1'b0;
      shift_q <= '1;
      bit_cnt <= '0;
      len_q   <= '0;
      div_q   <= 16'd1;
    end
    else if (load)
    begin
      tx_busy <= 1'b1;
      shift_q <= frame;
      bit_cnt <= '0;
      len_q   <= frame_len;
      div_q   <= (line_cfg.divisor == 16'd0) ? 16'd1 : line_cfg.divisor;
    end
    else if (bit_tick)
    begin
      shift_q <= {1'b1, shift_q[FRAME_W-1:1]};
      bit_cnt <= bit_cnt + 4'd1;
      if (bit_cnt == len_q - 4'd1)
        tx_busy <= 1'b0;
    end
  end

  line_idle_high: assert property (@(posedge baudclk_221184kHz) disable iff (!reset)
    !tx_busy |-> tx)
    else $error("tx low while serializer idle");

endmodule

/* src/uart_tx_top.sv */
module uart_tx_top #(
  parameter int PRESCALE = 192,
  parameter int DEPTH    = 16
) (
  input  logic                             reset,
  input  logic                             baudclk_221184kHz,
  input  logic                             wb_cyc,
  input  logic                             wb_stb,
  input  logic                             wb_we,
  input  logic [2:0]                       wb_adr,
  input  logic [uart_tx_pkg::DATA_W-1:0]   wb_dat_w,
  output logic                             wb_ack,
  output logic [uart_tx_pkg::DATA_W-1:0]   wb_dat_r,
  output logic                             tx
);

  uart_tx_pkg::line_cfg_t line_cfg;
  logic                   tx_busy;

  // regs push, fifo buffers, serializer drains
  tx_queue_if #(.DATA_W(uart_tx_pkg::DATA_W)) tx_q ();

  uart_regs uart_regs_inst (
    .reset             (reset),
    .baudclk_221184kHz (baudclk_221184kHz),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_dat_w          (wb_dat_w),
    .wb_ack            (wb_ack),
    .wb_dat_r          (wb_dat_r),
    .q                 (tx_q.writer),
    .tx_busy           (tx_busy),
    .line_cfg          (line_cfg)
  );

  tx_fifo #(.DEPTH(DEPTH)) tx_fifo_inst (
    .reset             (reset),
    .baudclk_221184kHz (baudclk_221184kHz),
    .q                 (tx_q.queue)
  );

  uart_serializer #(.PRESCALE(PRESCALE)) uart_serializer_inst (
    .reset             (reset),
    .baudclk_221184kHz (baudclk_221184kHz),
    .q                 (tx_q.reader),
    .line_cfg          (line_cfg),
    .tx_busy           (tx_busy),
    .tx                (tx)
  );

endmodule

/* bench/uart_tx_tb.sv */
module uart_tx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PRESCALE    = 4;
  localparam int DEPTH       = 16;
  // framing 40, bit time 3, burst 16
  localparam int FRAMES      = 59;
  localparam int CYCLE_LIMIT = FRAMES * 12 * PRESCALE * 3 + 2000;

  logic        baudclk_221184kHz = 1'b0;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [7:0]  wb_dat_w;
  logic        wb_ack;
  logic [7:0]  wb_dat_r;
  logic        tx;
  logic [31:0] rng_state = 32'd86651;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_bad = 0;
  int          cycle_count = 0;
  logic [7:0]  cur_lcr = 8'h00;
  int          cur_div = 12;
  // scoreboard, one entry per THR write
  logic [7:0]  exp_data[$];
  logic [7:0]  exp_lcr[$];
  int          exp_div[$];

  uart_tx_top #(.PRESCALE(PRESCALE), .DEPTH(DEPTH)) uart_tx_top_inst (
    .reset             (reset),
    .baudclk_221184kHz (baudclk_221184kHz),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_dat_w          (wb_dat_w),
    .wb_ack            (wb_ack),
    .wb_dat_r          (wb_dat_r),
    .tx                (tx)
  );

  always #10 baudclk_221184kHz = ~baudclk_221184kHz;

  always @(posedge baudclk_221184kHz)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // expected line bits for one byte, returns the frame length
  function automatic int frame_bits(input logic [7:0] data, input logic [7:0] lcr,
                                    output logic [11:0] bits);
    int   nbits;
    int   n;
    logic par;
    nbits   = 5 + int'(lcr[1:0]);
    bits    = '1;
    bits[0] = 1'b0;
    par     = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      bits[i + 1] = data[i];
      par = par ^ data[i];
    end
    n = nbits + 1;
    if (lcr[3])
    begin
      if (lcr[5])
        bits[n] = ~lcr[4];
      else
        bits[n] = lcr[4] ? par : ~par;
      n++;
    end
    n = n + (lcr[2] ? 2 : 1);
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    int waited;
    @(posedge baudclk_221184kHz);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    waited = 0;
    do
    begin
      @(negedge baudclk_221184kHz);
      waited++;
    end
    while (!wb_ack && waited < 8);
    assert (wb_ack === 1'b1 && waited == 2) else
    begin
      $display("bus access at offset %0d was not acked in its second cycle", adr);
      errors++;
    end
    rdat = wb_dat_r;
    @(posedge baudclk_221184kHz);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [7:0] data);
    logic [7:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic check_read(input logic [2:0] adr, input logic [7:0] expected,
                            input string what);
    logic [7:0] got;
    wb_access(1'b0, adr, 8'h00, got);
    assert (got === expected) else
    begin
      $display("ERR wb_dat_r %s got %h expected %h", what, got, expected);
      errors++;
    end
  endtask

  task automatic set_line(input logic [7:0] lcr, input int div);
    wb_write(uart_tx_pkg::ADDR_LCR, lcr | 8'h80);
    wb_write(uart_tx_pkg::ADDR_THR_DLL, 8'(div));
    wb_write(uart_tx_pkg::ADDR_DLM, 8'(div >> 8));
    wb_write(uart_tx_pkg::ADDR_LCR, lcr);
    cur_lcr = lcr;
    cur_div = div;
  endtask

  task automatic send_byte(input logic [7:0] data);
    exp_data.push_back(data);
    exp_lcr.push_back(cur_lcr);
    exp_div.push_back(cur_div);
    wb_write(uart_tx_pkg::ADDR_THR_DLL, data);
  endtask

  // poll until TEMT, every queued frame must be out by then
  task automatic drain();
    logic [7:0] lsr;
    lsr = 8'h00;
    while (!lsr[6])
      wb_access(1'b0, uart_tx_pkg::ADDR_LSR, 8'h00, lsr);
    assert (exp_data.size() == 0) else
    begin
      $display("%0d written bytes never appeared on tx", exp_data.size());
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_at_start);
    tests_run++;
    if (errors == errors_at_start)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: %0d errors", name, errors - errors_at_start);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // line model, samples tx once per cycle from the start edge
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : line_monitor
    logic [11:0] exp_bits;
    logic [11:0] got_bits;
    logic [7:0]  m_data;
    logic [7:0]  m_lcr;
    int          t;
    int          len;
    int          low_run;
    logic        high_seen;
    wait (reset === 1'b1);
    forever
    begin
      @(negedge tx);
      assert (exp_data.size() != 0) else
      begin
        $display("frame started on tx with no byte written");
        errors++;
      end
      if (exp_data.size() == 0)
        @(posedge tx);
      else
      begin
        m_data    = exp_data.pop_front();
        m_lcr     = exp_lcr.pop_front();
        t         = PRESCALE * exp_div.pop_front();
        len       = frame_bits(m_data, m_lcr, exp_bits);
        got_bits  = '1;
        low_run   = 0;
        high_seen = 1'b0;
        for (int n = 1; n <= len * t; n++)
        begin
          @(negedge baudclk_221184kHz);
          if (!high_seen && tx == 1'b0)
            low_run++;
          else
            high_seen = 1'b1;
          // mid-bit sample
          if (n >= t / 2 && (n - t / 2) % t == 0)
            got_bits[(n - t / 2) / t] = tx;
        end
        assert (got_bits == exp_bits) else
        begin
          $display("ERR tx frame got %h expected %h for data %h lcr %h",
                   got_bits, exp_bits, m_data, m_lcr);
          errors++;
        end
        // start bit length is only visible when data bit 0 is high
        assert (!exp_bits[1] || low_run == t) else
        begin
          $display("ERR tx start bit cycles got %h expected %h", low_run, t);
          errors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic [7:0]  v;
    int          mark;
    reset    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 3'd0;
    wb_dat_w = 8'h00;
    repeat (8) @(posedge baudclk_221184kHz);
    reset <= 1'b1;

    mark = errors;
    check_read(uart_tx_pkg::ADDR_LCR, 8'h00, "LCR");
    check_read(uart_tx_pkg::ADDR_LSR, 8'h60, "LSR");
    check_read(uart_tx_pkg::ADDR_SCR, 8'h00, "SCR");
    wb_write(uart_tx_pkg::ADDR_LCR, 8'h80);
    check_read(uart_tx_pkg::ADDR_THR_DLL, 8'h0c, "DLL");
    check_read(uart_tx_pkg::ADDR_DLM, 8'h00, "DLM");
    wb_write(uart_tx_pkg::ADDR_LCR, 8'h00);
    @(negedge baudclk_221184kHz);
    assert (tx === 1'b1) else
    begin
      $display("ERR tx got %h expected 1", tx);
      errors++;
    end
    finish_test("reset values", mark);

    mark = errors;
    repeat (3)
    begin
      r = xorshift_next();
      wb_write(uart_tx_pkg::ADDR_SCR, r[7:0]);
      check_read(uart_tx_pkg::ADDR_SCR, r[7:0], "SCR");
      v = r[15:8] & 8'h7f;
      wb_write(uart_tx_pkg::ADDR_LCR, v | 8'h80);
      check_read(uart_tx_pkg::ADDR_LCR, v | 8'h80, "LCR");
      // offset 0 with DLAB set lands in DLL, not the fifo
      wb_write(uart_tx_pkg::ADDR_THR_DLL, r[23:16]);
      wb_write(uart_tx_pkg::ADDR_DLM, r[31:24]);
      check_read(uart_tx_pkg::ADDR_THR_DLL, r[23:16], "DLL");
      check_read(uart_tx_pkg::ADDR_DLM, r[31:24], "DLM");
      wb_write(uart_tx_pkg::ADDR_LCR, v);
      check_read(uart_tx_pkg::ADDR_LCR, v, "LCR");
    end
    repeat (PRESCALE * 24) @(negedge baudclk_221184kHz);
    check_read(uart_tx_pkg::ADDR_LSR, 8'h60, "LSR");
    finish_test("register readback", mark);

    // 10 line settings with 4 bytes each
    mark = errors;
    repeat (10)
    begin
      drain();
      r = xorshift_next();
      set_line(r[7:0] & 8'h3f, 1 + int'(r[15:8] % 8'd3));
      repeat (4)
      begin
        r = xorshift_next();
        send_byte(r[7:0]);
      end
    end
    drain();
    finish_test("framing", mark);

    mark = errors;
    for (int d = 1; d <= 3; d++)
    begin
      drain();
      r = xorshift_next();
      set_line(8'h03, d);
      send_byte(r[7:0] | 8'h01);
    end
    drain();
    finish_test("bit time", mark);

    mark = errors;
    r = xorshift_next();
    set_line(r[7:0] & 8'h3f, 1 + int'(r[15:8] % 8'd3));
    repeat (DEPTH)
    begin
      r = xorshift_next();
      send_byte(r[7:0]);
    end
    wb_access(1'b0, uart_tx_pkg::ADDR_LSR, 8'h00, v);
    assert (v[5] == 1'b0) else
    begin
      $display("ERR wb_dat_r LSR THRE got %h expected 0", v[5]);
      errors++;
    end
    drain();
    check_read(uart_tx_pkg::ADDR_LSR, 8'h60, "LSR");
    finish_test("burst", mark);

    $display("summary: %0d tests run, %0d with errors, %0d errors in all",
             tests_run, tests_bad, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* uart_tx_top.f */
src/uart_tx_pkg.sv
src/tx_queue_if.sv
src/uart_regs.sv
src/tx_fifo.sv
src/uart_serializer.sv
src/uart_tx_top.sv
bench/uart_tx_tb.sv

/* Makefile */
# verilator build and run of the uart transmitter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module uart_tx_tb -f uart_tx_top.f -o uart_tx_tb

run: compile
	./obj_dir/uart_tx_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
